// File: bench/regs_cases.txt
// op rd value inst delay known rs1 rs2 rs3, all hex
// op 0 = no write, 1 = write value, 2 = write random value, f = end
// Reset values, x2 is the stack pointer
0 00 00000000 00110033 0 1 00010000 00000000 00000000
0 00 00000000 002F8033 0 1 00000000 00010000 00000000
0 00 00000000 11E28043 0 1 00000000 00000000 00010000
// Write to x0 is dropped
1 00 DEADBEEF 00000043 3 1 00000000 00000000 00000000
// Two cycles after the strobe the old value, three cycles after the new one
1 05 12345678 00528033 2 1 00000000 00000000 00000000
0 00 00000000 00528033 0 1 12345678 12345678 00000000
1 06 A5A5A5A5 00530033 3 1 A5A5A5A5 12345678 00000000
1 02 CAFEF00D 00610033 2 1 00010000 A5A5A5A5 00000000
0 00 00000000 00610033 0 1 CAFEF00D A5A5A5A5 00000000
// rs3 for each R4 opcode
0 00 00000000 28230043 0 1 A5A5A5A5 CAFEF00D 12345678
0 00 00000000 30510047 0 1 CAFEF00D 12345678 A5A5A5A5
0 00 00000000 1000004B 0 1 00000000 00000000 CAFEF00D
0 00 00000000 2862804F 0 1 12345678 A5A5A5A5 12345678
// Other opcodes read zero on rs3
0 00 00000000 28230033 0 1 A5A5A5A5 CAFEF00D 00000000
0 00 00000000 F8628053 0 1 12345678 A5A5A5A5 00000000
0 00 00000000 10010044 0 1 CAFEF00D 00000000 00000000
// Back to back random writes, then read them all back
2 0A 00000000 00000033 0 1 00000000 00000000 00000000
2 0B 00000000 00000033 0 1 00000000 00000000 00000000
2 0C 00000000 00000033 0 1 00000000 00000000 00000000
2 0D 00000000 00000033 0 1 00000000 00000000 00000000
2 0E 00000000 00000033 0 1 00000000 00000000 00000000
2 0F 00000000 00000033 0 1 00000000 00000000 00000000
0 00 00000000 60B50043 2 0 00000000 00000000 00000000
0 00 00000000 78E68043 0 0 00000000 00000000 00000000
// Same register twice in a row, second value stays
1 07 11111111 00000033 0 1 00000000 00000000 00000000
1 07 22222222 00738033 3 1 22222222 22222222 00000000
0 00 00000000 0000004F 0 1 00000000 00000000 00000000
F 00 00000000 00000000 0 0 00000000 00000000 00000000

// File: files.f
logic/cpu_pkg.sv
logic/operand_decode.sv
logic/writeback_port.sv
logic/register_file.sv
logic/regs_top.sv
bench/regs_checker.sv
bench/regs_tb.sv

// File: Makefile
SOURCES = $(shell cat files.f)

obj_dir/regs_sim: $(SOURCES) files.f
	verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module regs_tb -o regs_sim

run: obj_dir/regs_sim
	@out="$$(./obj_dir/regs_sim)"; echo "$$out"; echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: bench/regs_tb.sv
`timescale 1ns/1ps

module regs_tb import cpu_pkg::*; ();

	localparam int MAX_ROWS = 64;
	localparam int FIELDS = 9;
	localparam int CHECK_TIMEOUT = 20;

	logic clock;
	logic reset;
	inst_t inst;
	logic wb_strobe;
	reg_index_t wb_rd;
	word_t wb_value;
	word_t rs1;
	word_t rs2;
	word_t rs3;

	logic check;
	int test_num;
	logic known;
	word_t exp_rs1;
	word_t exp_rs2;
	word_t exp_rs3;
	int tests_done;
	int tests_failed;

	// Fields per row are op rd value inst delay known rs1 rs2 rs3
	logic [31:0] cases_mem [MAX_ROWS * FIELDS];

	regs_top uut (
		.i_clock(clock),
		.i_reset(reset),
		.i_inst(inst),
		.i_wb_strobe(wb_strobe),
		.i_wb_rd(wb_rd),
		.i_wb_value(wb_value),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_rs3(rs3)
	);

	regs_checker u_checker (
		.i_clock(clock),
		.i_reset(reset),
		.i_inst(inst),
		.i_wb_strobe(wb_strobe),
		.i_wb_rd(wb_rd),
		.i_wb_value(wb_value),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_rs3(rs3),
		.i_check(check),
		.i_test_num(test_num),
		.i_known(known),
		.i_exp_rs1(exp_rs1),
		.i_exp_rs2(exp_rs2),
		.i_exp_rs3(exp_rs3),
		.o_tests_done(tests_done),
		.o_tests_failed(tests_failed)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	task automatic wait_cycles(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clock);
		end
	endtask

	// Inputs change just after the edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic present_read(input int row, input logic active);
		int base;
		base = row * FIELDS;
		check = active;
		if (active) begin
			inst = cases_mem[base + 3];
			test_num = row + 1;
			known = cases_mem[base + 5][0];
			exp_rs1 = cases_mem[base + 6];
			exp_rs2 = cases_mem[base + 7];
			exp_rs3 = cases_mem[base + 8];
		end else begin
			inst = 32'd0;
		end
	endtask

	// Strobe goes out first and the read follows after the row's delay
	task automatic run_row(input int row);
		int base;
		int delay;
		logic [31:0] op;
		base = row * FIELDS;
		op = cases_mem[base];
		delay = int'(cases_mem[base + 4]);
		next_cycle();
		wb_strobe = (op != 32'd0);
		wb_rd = cases_mem[base + 1][4:0];
		if (op == 32'd2) begin
			wb_value = $urandom;
		end else begin
			wb_value = cases_mem[base + 2];
		end
		present_read(row, delay == 0);
		for (int d = 1; d <= delay; d++) begin
			next_cycle();
			wb_strobe = 1'b0;
			present_read(row, d == delay);
		end
	endtask

	task automatic wait_for_checks(input int expected, output logic timed_out);
		int cycles;
		cycles = 0;
		timed_out = 1'b0;
		while (tests_done < expected && !timed_out) begin
			@(posedge clock);
			cycles++;
			if (cycles > CHECK_TIMEOUT) begin
				$display("timeout: checker reported %0d of %0d tests", tests_done, expected);
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		logic timed_out;
		int row_count;
		void'($urandom(72));
		reset = 1'b1;
		inst = 32'd0;
		wb_strobe = 1'b0;
		wb_rd = 5'd0;
		wb_value = 32'd0;
		check = 1'b0;
		test_num = 0;
		known = 1'b0;
		exp_rs1 = 32'd0;
		exp_rs2 = 32'd0;
		exp_rs3 = 32'd0;
		for (int i = 0; i < MAX_ROWS * FIELDS; i++) begin
			cases_mem[i] = '1;
		end
		$readmemh("bench/regs_cases.txt", cases_mem);
		wait_cycles(5);
		#1 reset = 1'b0;
		row_count = 0;
		// An op above 2 ends the list
		while (row_count < MAX_ROWS && cases_mem[row_count * FIELDS] <= 32'd2) begin
			run_row(row_count);
			row_count++;
		end
		next_cycle();
		wb_strobe = 1'b0;
		check = 1'b0;
		inst = 32'd0;
		wait_for_checks(row_count, timed_out);
		if (row_count == 0) begin
			$display("no test rows were read from the cases file");
		end
		$display("tests run %0d, failed %0d", tests_done, tests_failed);
		if (!timed_out && row_count > 0 && tests_failed == 0 && tests_done == row_count) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: bench/regs_checker.sv
`timescale 1ns/1ps

module regs_checker import cpu_pkg::*; (
	input i_clock,
	input i_reset,

	// DUT ports
	input inst_t i_inst,
	input i_wb_strobe,
	input reg_index_t i_wb_rd,
	input word_t i_wb_value,
	input word_t i_rs1,
	input word_t i_rs2,
	input word_t i_rs3,

	// Test read presented this cycle, with the values from the cases file
	input i_check,
	input int i_test_num,
	input i_known,
	input word_t i_exp_rs1,
	input word_t i_exp_rs2,
	input word_t i_exp_rs3,

	output int o_tests_done,
	output int o_tests_failed
);

	word_t model [REG_COUNT];

	// Writes seen one and two edges ago
	logic wr_valid_d1;
	logic wr_valid_d2;
	reg_index_t wr_rd_d1;
	reg_index_t wr_rd_d2;
	word_t wr_value_d1;
	word_t wr_value_d2;

	logic pend_valid;
	logic pend_known;
	int pend_test;
	word_t model_rs1;
	word_t model_rs2;
	word_t model_rs3;
	word_t file_rs1;
	word_t file_rs2;
	word_t file_rs3;

	// Only the R4 opcodes name a third source
	function automatic reg_index_t rs3_field(input inst_t inst);
		reg_index_t index;
		index = 5'd0;
		if (inst[6:0] == OPCODE_MADD || inst[6:0] == OPCODE_MSUB ||
				inst[6:0] == OPCODE_NMSUB || inst[6:0] == OPCODE_NMADD) begin
			index = inst[31:27];
		end
		return index;
	endfunction

	function automatic word_t model_read(input reg_index_t index);
		word_t value;
		value = 32'd0;
		if (index != 5'd0) begin
			value = model[index];
		end
		return value;
	endfunction

	task automatic compare_word(input string name, input string source, input word_t actual,
			input word_t expected, inout logic failed);
		if (actual !== expected) begin
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h (%s)",
				$time, name, expected, actual, source);
			failed = 1'b1;
		end
	endtask

	always @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				if (i == 2) begin
					model[i] <= STACK_POINTER;
				end else begin
					model[i] <= 32'd0;
				end
			end
			wr_valid_d1 <= 1'b0;
			wr_valid_d2 <= 1'b0;
			pend_valid <= 1'b0;
			pend_known <= 1'b0;
			pend_test <= 0;
		end else begin
			// Operands see the contents from before this edge's write
			pend_valid <= i_check;
			if (i_check) begin
				pend_test <= i_test_num;
				pend_known <= i_known;
				model_rs1 <= model_read(i_inst[19:15]);
				model_rs2 <= model_read(i_inst[24:20]);
				model_rs3 <= model_read(rs3_field(i_inst));
				file_rs1 <= i_exp_rs1;
				file_rs2 <= i_exp_rs2;
				file_rs3 <= i_exp_rs3;
			end
			wr_valid_d1 <= i_wb_strobe;
			wr_rd_d1 <= i_wb_rd;
			wr_value_d1 <= i_wb_value;
			wr_valid_d2 <= wr_valid_d1;
			wr_rd_d2 <= wr_rd_d1;
			wr_value_d2 <= wr_value_d1;
			// Strobe lands two edges after it is sampled, x0 never changes
			if (wr_valid_d2 && wr_rd_d2 != 5'd0) begin
				model[wr_rd_d2] <= wr_value_d2;
			end
		end
	end

	// Operands settle after the edge, so compare mid-cycle
	always @(negedge i_clock or posedge i_reset) begin
		logic failed;
		if (i_reset) begin
			o_tests_done <= 0;
			o_tests_failed <= 0;
		end else if (pend_valid) begin
			failed = 1'b0;
			compare_word("o_rs1", "model", i_rs1, model_rs1, failed);
			compare_word("o_rs2", "model", i_rs2, model_rs2, failed);
			compare_word("o_rs3", "model", i_rs3, model_rs3, failed);
			if (pend_known) begin
				compare_word("o_rs1", "cases file", i_rs1, file_rs1, failed);
				compare_word("o_rs2", "cases file", i_rs2, file_rs2, failed);
				compare_word("o_rs3", "cases file", i_rs3, file_rs3, failed);
			end
			if (failed) begin
				$display("test %0d failed", pend_test);
				o_tests_failed <= o_tests_failed + 1;
			end else begin
				$display("test %0d passed", pend_test);
			end
			o_tests_done <= o_tests_done + 1;
		end
	end

endmodule

// File: logic/regs_top.sv
`timescale 1ns/1ps

module regs_top import cpu_pkg::*; (
	input i_clock,
	input i_reset,

	input inst_t i_inst,

	input i_wb_strobe,
	input reg_index_t i_wb_rd,
	input word_t i_wb_value,

	output word_t o_rs1,
	output word_t o_rs2,
	output word_t o_rs3
);

	reg_index_t rs1_index;
	reg_index_t rs2_index;
	reg_index_t rs3_index;

	reg_index_t wb_rd;
	word_t wb_value;
	tag_t wb_tag;

	operand_decode u_operand_decode (
		.i_inst(i_inst),
		.o_rs1_index(rs1_index),
		.o_rs2_index(rs2_index),
		.o_rs3_index(rs3_index)
	);

	// Stands in for the memory stage output
	writeback_port u_writeback_port (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wb_strobe(i_wb_strobe),
		.i_wb_rd(i_wb_rd),
		.i_wb_value(i_wb_value),
		.o_wb_rd(wb_rd),
		.o_wb_value(wb_value),
		.o_wb_tag(wb_tag)
	);

	register_file u_register_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_index(rs1_index),
		.i_rs2_index(rs2_index),
		.i_rs3_index(rs3_index),
		.o_rs1(o_rs1),
		.o_rs2(o_rs2),
		.o_rs3(o_rs3),
		.i_wb_rd(wb_rd),
		.i_wb_value(wb_value),
		.i_wb_tag(wb_tag)
	);

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input i_clock,
	input i_reset,

	input reg_index_t i_rs1_index,
	input reg_index_t i_rs2_index,
	input reg_index_t i_rs3_index,

	output word_t o_rs1,
	output word_t o_rs2,
	output word_t o_rs3,

	input reg_index_t i_wb_rd,
	input word_t i_wb_value,
	input tag_t i_wb_tag
);

	word_t regs [REG_COUNT];
	tag_t last_tag;
	logic wb_new;

	// x0 is hard-wired, whatever the array holds
	function automatic word_t read_operand(input reg_index_t index);
		word_t value;
		if (index == '0) begin
			value = '0;
		end else begin
			value = regs[index];
		end
		return value;
	endfunction

	assign wb_new = (i_wb_tag != last_tag);

	// Read first, sampled before any write of this edge lands
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			o_rs1 <= '0;
			o_rs2 <= '0;
			o_rs3 <= '0;
		end else begin
			o_rs1 <= read_operand(i_rs1_index);
			o_rs2 <= read_operand(i_rs2_index);
			o_rs3 <= read_operand(i_rs3_index);
		end
	end

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			last_tag <= '0;
		end else if (wb_new) begin
			last_tag <= i_wb_tag;
		end
	end

	// Write later
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				// x2 starts as the stack pointer
				if (i == 2) begin
					regs[i] <= STACK_POINTER;
				end else begin
					regs[i] <= '0;
				end
			end
		end else if (wb_new && (i_wb_rd != '0)) begin
			regs[i_wb_rd] <= i_wb_value;
		end
	end

endmodule

// File: logic/writeback_port.sv
`timescale 1ns/1ps

module writeback_port import cpu_pkg::*; (
	input i_clock,
	input i_reset,

	input i_wb_strobe,
	input reg_index_t i_wb_rd,
	input word_t i_wb_value,

	output reg_index_t o_wb_rd,
	output word_t o_wb_value,
	output tag_t o_wb_tag
);

	logic pending_valid;
	reg_index_t pending_rd;
	word_t pending_value;

	// Strobe captured, record not yet published
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			pending_valid <= 1'b0;
		end else begin
			pending_valid <= i_wb_strobe;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_wb_strobe) begin
			pending_rd <= i_wb_rd;
			pending_value <= i_wb_value;
		end
	end

	// New tag marks the record as a fresh write
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			o_wb_tag <= '0;
		end else if (pending_valid) begin
			o_wb_tag <= o_wb_tag + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (pending_valid) begin
			o_wb_rd <= pending_rd;
			o_wb_value <= pending_value;
		end
	end

endmodule

// File: logic/operand_decode.sv
`timescale 1ns/1ps

module operand_decode import cpu_pkg::*; (
	input inst_t i_inst,

	output reg_index_t o_rs1_index,
	output reg_index_t o_rs2_index,
	output reg_index_t o_rs3_index
);

	logic [6:0] opcode;
	logic is_r4;

	assign opcode = i_inst[6:0];

	// rs1 and rs2 sit at the same place in every format that has them
	assign o_rs1_index = i_inst[19:15];
	assign o_rs2_index = i_inst[24:20];

	always_comb begin
		case (opcode)
			OPCODE_MADD: begin
				is_r4 = 1'b1;
			end
			OPCODE_MSUB: begin
				is_r4 = 1'b1;
			end
			OPCODE_NMSUB: begin
				is_r4 = 1'b1;
			end
			OPCODE_NMADD: begin
				is_r4 = 1'b1;
			end
			default: begin
				is_r4 = 1'b0;
			end
		endcase
	end

	// Outside R4 the top bits belong to funct7, so point rs3 at x0
	assign o_rs3_index = is_r4 ? i_inst[31:27] : '0;

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	// Data and instruction words
	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;

	// Index into the integer register file
	typedef logic [4:0] reg_index_t;

	// Writeback tag, wraps around
	typedef logic [2:0] tag_t;

	// Integer register count, x0 included
	localparam int REG_COUNT = 32;

	// Reset value of x2
	localparam word_t STACK_POINTER = 32'h0001_0000;

	// Fused multiply-add opcodes, the only ones that read rs3
	localparam logic [6:0] OPCODE_MADD = 7'b1000011;
	localparam logic [6:0] OPCODE_MSUB = 7'b1000111;
	localparam logic [6:0] OPCODE_NMSUB = 7'b1001011;
	localparam logic [6:0] OPCODE_NMADD = 7'b1001111;

endpackage
